// File: include/omegaNet_defs.svh
// Size macros for the 8-lane omega network; include wherever lane, level or field widths are needed.
`ifndef OMEGANET_DEFS_SVH
`define OMEGANET_DEFS_SVH

// The network has as many outputs as inputs.
// Both counts are the same power of two.
`define OMEGA_LANES 8

// One level of 2x2 switches resolves one destination bit.
// Three levels cover eight lanes.
`define OMEGA_LEVELS 3

// Each level holds half as many switches as there are lanes.
`define OMEGA_SWITCHES 4

// Width of the user payload carried by every word.
`define OMEGA_DATA_W 16

// Width of a lane index.
// The same width serves the destination output and the source input of a word.
`define OMEGA_DEST_W 3

`endif

// File: hdl/omegaPktPkg.sv
// Packet type for the words that travel over every link of the omega network; import where used.
package omegaPktPkg;

  `include "omegaNet_defs.svh"

  // One word as it moves between the network levels.
  // The fields are ordered from the most significant end of the word.
  // The destination is read bit by bit, one bit at each level.
  // The most significant destination bit steers level 0.
  // The source index is filled in when the word enters the network.
  // The switches never change it on the way through.
  // The payload is carried through untouched.
  typedef struct packed {
    // Output lane that the word must reach.
    logic [`OMEGA_DEST_W-1:0] dest;
    // Input lane that the word entered at.
    logic [`OMEGA_DEST_W-1:0] srcIdx;
    // User data.
    logic [`OMEGA_DATA_W-1:0] payload;
  } omegaPkt_t;

endpackage

// File: hdl/omegaArbPkg.sv
// Request and grant vector types for the two-input switch arbiters; import where used.
package omegaArbPkg;

  // One bit per switch input.
  // Bit k is set when input k holds a valid word for the arbitrated output.
  typedef logic [1:0] arbReq_t;

  // One bit per switch input as well.
  // At most one bit is set.
  // A set bit routes that input to the output this cycle.
  // An all-zero grant means the output sees no request.
  typedef logic [1:0] arbGrant_t;

endpackage

// File: hdl/omegaLinkIf.sv
// Valid/ready link carrying one network word; instantiate per link and connect through modports.
`timescale 1ns/1ps

interface omegaLinkIf import omegaPktPkg::*; ();

  // A transfer takes place on a rising edge where valid and ready are both high.
  logic      valid;
  logic      ready;
  omegaPkt_t pkt;

  // The sending side owns valid and the word.
  // Once valid rises, both stay stable until the transfer.
  modport sender (
    output valid,
    output pkt,
    input  ready
  );

  // The receiving side owns ready.
  // Its ready may depend on valid.
  modport receiver (
    input  valid,
    input  pkt,
    output ready
  );

endinterface

// File: hdl/rrArbiter.sv
// Round-robin arbiter for two requesters with grant lock-in; one sits at each switch output.
`timescale 1ns/1ps

module rrArbiter import omegaArbPkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  arbReq_t   req_i,
  input  logic      hold_i,
  output arbGrant_t grant_o
);

  // Priority pointer.
  // When set, requester 1 wins a tie, otherwise requester 0 does.
  logic      favorOne;
  // Set while a granted word waits for the downstream buffer.
  logic      locked;
  arbGrant_t lockedGrant;
  arbGrant_t freeGrant;

  // Without a tie the single requester, or nobody, gets the output.
  // A tie goes to the requester that was not served last.
  always_comb begin
    if (req_i == 2'b11) begin
      freeGrant = favorOne ? 2'b10 : 2'b01;
    end else begin
      freeGrant = req_i;
    end
  end

  // A stalled grant is kept, so the word on the output never changes under valid.
  assign grant_o = locked ? lockedGrant : freeGrant;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      favorOne    <= 1'b0;
      locked      <= 1'b0;
      lockedGrant <= '0;
    end else begin
      locked      <= hold_i;
      lockedGrant <= grant_o;
      // A grant without hold is a completed transfer.
      // The pointer then moves past the requester just served.
      if (|grant_o && !hold_i) begin
        favorOne <= grant_o[0];
      end
    end
  end

endmodule

// File: hdl/spillRegister.sv
// Two-entry output buffer of a stream switch; cuts the valid, data and ready paths between levels.
`timescale 1ns/1ps

module spillRegister import omegaPktPkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  omegaLinkIf.receiver up,
  omegaLinkIf.sender   down
);

  // The main entry always holds the oldest word and drives the downstream link.
  logic      mainValid;
  omegaPkt_t mainPkt;
  // The spill entry catches a word that arrives while the main entry is stalled.
  logic      spillValid;
  omegaPkt_t spillPkt;
  logic      upFire;
  logic      downFire;

  // Upstream ready comes straight from a flop.
  // No combinational path runs from down.ready to up.ready.
  assign up.ready   = !spillValid;
  assign down.valid = mainValid;
  assign down.pkt   = mainPkt;

  assign upFire   = up.valid && !spillValid;
  assign downFire = mainValid && down.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mainValid  <= 1'b0;
      spillValid <= 1'b0;
    end else if (spillValid) begin
      // Both entries are full, so the main entry stays valid.
      // The spilled word moves up when the main word leaves.
      if (downFire) begin
        spillValid <= 1'b0;
      end
    end else begin
      // A new word parks in the spill entry only while the main word is stuck.
      if (upFire && mainValid && !downFire) begin
        spillValid <= 1'b1;
      end
      if (upFire) begin
        mainValid <= 1'b1;
      end else if (downFire) begin
        mainValid <= 1'b0;
      end
    end
  end

  // Word storage follows the same cases as the flags above.
  // Words therefore leave in arrival order.
  always_ff @(posedge clk_i) begin
    if (spillValid) begin
      if (downFire) begin
        mainPkt <= spillPkt;
      end
    end else if (upFire) begin
      if (!mainValid || downFire) begin
        mainPkt <= up.pkt;
      end else begin
        spillPkt <= up.pkt;
      end
    end
  end

endmodule

// File: hdl/streamSwitch.sv
// 2x2 stream switch of one network level; routes each input by one destination bit and buffers outputs.
`timescale 1ns/1ps
`include "omegaNet_defs.svh"

module streamSwitch import omegaArbPkg::*; #(
  // Position of this switch's level in the network, counted from the inputs.
  parameter int unsigned levelIdx = 0
) (
  input  logic         clk_i,
  input  logic         rst_i,
  omegaLinkIf.receiver inLink [2],
  omegaLinkIf.sender   outLink [2]
);

  // Level 0 looks at the most significant destination bit.
  // Each later level looks one bit further down.
  localparam int unsigned selBit = `OMEGA_LEVELS - 1 - levelIdx;

  // Output port that each input asks for.
  logic [1:0] route;
  logic [1:0] inValid;
  arbReq_t    reqs [2];
  arbGrant_t  grants [2];
  logic [1:0] holds;

  // Links from the arbitration muxes into the output buffers.
  omegaLinkIf stage [2] ();

  for (genvar k = 0; k < 2; k++) begin : genInput
    assign route[k]   = inLink[k].pkt.dest[selBit];
    assign inValid[k] = inLink[k].valid;
    // An input can be granted by at most one output, the one it routes to.
    // The losing input sees ready low until its turn comes.
    assign inLink[k].ready = (grants[0][k] && stage[0].ready) ||
                             (grants[1][k] && stage[1].ready);
  end

  for (genvar o = 0; o < 2; o++) begin : genOutput
    // Requests for output o come from every valid input whose routing bit equals o.
    assign reqs[o] = {inValid[1] && (route[1] == 1'(o)),
                      inValid[0] && (route[0] == 1'(o))};

    rrArbiter uArb (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (reqs[o]),
      .hold_i  (holds[o]),
      .grant_o (grants[o])
    );

    // The granted word passes unchanged into the buffer.
    assign stage[o].valid = |(grants[o] & reqs[o]);
    assign stage[o].pkt   = grants[o][1] ? inLink[1].pkt : inLink[0].pkt;

    // A full buffer keeps the current grant in place for the next cycle.
    assign holds[o] = stage[o].valid && !stage[o].ready;

    spillRegister uSpill (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .up    (stage[o]),
      .down  (outLink[o])
    );
  end

endmodule

// File: hdl/omegaNet.sv
// Omega network core; three levels of 2x2 stream switches joined by perfect-shuffle wiring.
`timescale 1ns/1ps
`include "omegaNet_defs.svh"

module omegaNet import omegaPktPkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  omegaLinkIf.receiver inLink [`OMEGA_LANES],
  omegaLinkIf.sender   outLink [`OMEGA_LANES]
);

  // Lane-indexed signals on the input side and the output side of every level.
  // Lane L of a level belongs to switch L/2, port L%2.
  logic      [`OMEGA_LEVELS-1:0][`OMEGA_LANES-1:0] swInValid;
  logic      [`OMEGA_LEVELS-1:0][`OMEGA_LANES-1:0] swInReady;
  omegaPkt_t [`OMEGA_LEVELS-1:0][`OMEGA_LANES-1:0] swInPkt;
  logic      [`OMEGA_LEVELS-1:0][`OMEGA_LANES-1:0] swOutValid;
  logic      [`OMEGA_LEVELS-1:0][`OMEGA_LANES-1:0] swOutReady;
  omegaPkt_t [`OMEGA_LEVELS-1:0][`OMEGA_LANES-1:0] swOutPkt;

  // The inputs enter level 0 in reversed order.
  // Input p feeds lane 7-p, and its word is stamped with p as the source index.
  for (genvar lane = 0; lane < `OMEGA_LANES; lane++) begin : genInputs
    localparam int unsigned port = `OMEGA_LANES - 1 - lane;

    assign swInValid[0][lane] = inLink[port].valid;
    assign swInPkt[0][lane]   = '{dest:    inLink[port].pkt.dest,
                                  srcIdx:  `OMEGA_DEST_W'(port),
                                  payload: inLink[port].pkt.payload};
    assign inLink[port].ready = swInReady[0][lane];
  end

  // Perfect shuffle between levels.
  // Output lane L goes to switch L mod 4, port L div 4 of the next level.
  for (genvar lvl = 0; lvl < `OMEGA_LEVELS - 1; lvl++) begin : genShuffle
    for (genvar lane = 0; lane < `OMEGA_LANES; lane++) begin : genLane
      localparam int unsigned dstLane =
          2 * (lane % `OMEGA_SWITCHES) + lane / `OMEGA_SWITCHES;

      assign swInValid[lvl+1][dstLane] = swOutValid[lvl][lane];
      assign swInPkt[lvl+1][dstLane]   = swOutPkt[lvl][lane];
      assign swOutReady[lvl][lane]     = swInReady[lvl+1][dstLane];
    end
  end

  // Each level of switches.
  // Every switch gets its own pair of links on each side.
  for (genvar lvl = 0; lvl < `OMEGA_LEVELS; lvl++) begin : genLevel
    for (genvar sw = 0; sw < `OMEGA_SWITCHES; sw++) begin : genSwitch
      omegaLinkIf swIn [2] ();
      omegaLinkIf swOut [2] ();

      for (genvar k = 0; k < 2; k++) begin : genPort
        assign swIn[k].valid          = swInValid[lvl][2*sw+k];
        assign swIn[k].pkt            = swInPkt[lvl][2*sw+k];
        assign swInReady[lvl][2*sw+k] = swIn[k].ready;

        assign swOutValid[lvl][2*sw+k] = swOut[k].valid;
        assign swOutPkt[lvl][2*sw+k]   = swOut[k].pkt;
        assign swOut[k].ready          = swOutReady[lvl][2*sw+k];
      end

      streamSwitch #(
        .levelIdx (lvl)
      ) uSwitch (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .inLink  (swIn),
        .outLink (swOut)
      );
    end
  end

  // Lane L of the last level is network output L.
  for (genvar lane = 0; lane < `OMEGA_LANES; lane++) begin : genOutputs
    assign outLink[lane].valid               = swOutValid[`OMEGA_LEVELS-1][lane];
    assign outLink[lane].pkt                 = swOutPkt[`OMEGA_LEVELS-1][lane];
    assign swOutReady[`OMEGA_LEVELS-1][lane] = outLink[lane].ready;
  end

endmodule

// File: hdl/omegaNetTop.sv
// Top level of the 8x8 omega network; maps flat valid/ready port arrays onto the network links.
`timescale 1ns/1ps
`include "omegaNet_defs.svh"

module omegaNetTop (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  // Input side, one handshake per input lane.
  input  logic [`OMEGA_LANES-1:0]                    inValid_i,
  output logic [`OMEGA_LANES-1:0]                    inReady_o,
  input  logic [`OMEGA_LANES-1:0][`OMEGA_DATA_W-1:0] inData_i,
  input  logic [`OMEGA_LANES-1:0][`OMEGA_DEST_W-1:0] inDest_i,
  // Output side, one handshake per output lane.
  output logic [`OMEGA_LANES-1:0]                    outValid_o,
  input  logic [`OMEGA_LANES-1:0]                    outReady_i,
  output logic [`OMEGA_LANES-1:0][`OMEGA_DATA_W-1:0] outData_o,
  output logic [`OMEGA_LANES-1:0][`OMEGA_DEST_W-1:0] outSrc_o
);

  omegaLinkIf inLinks [`OMEGA_LANES] ();
  omegaLinkIf outLinks [`OMEGA_LANES] ();

  for (genvar p = 0; p < `OMEGA_LANES; p++) begin : genPorts
    // The network fills in the source index itself, so it enters as zero here.
    assign inLinks[p].valid = inValid_i[p];
    assign inLinks[p].pkt   = '{dest:    inDest_i[p],
                                srcIdx:  '0,
                                payload: inData_i[p]};
    assign inReady_o[p]     = inLinks[p].ready;

    // Only the payload and the source index leave the network.
    // The destination is implied by the output lane.
    assign outValid_o[p]     = outLinks[p].valid;
    assign outData_o[p]      = outLinks[p].pkt.payload;
    assign outSrc_o[p]       = outLinks[p].pkt.srcIdx;
    assign outLinks[p].ready = outReady_i[p];
  end

  omegaNet uNet (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .inLink  (inLinks),
    .outLink (outLinks)
  );

endmodule

// File: verification/omegaNetChecks.sv
// Protocol and scoreboard checker for the omega network; the testbench instantiates it beside the DUT.
`timescale 1ns/1ps
`include "omegaNet_defs.svh"

module omegaNetChecks (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic [2:0]                                 testId_i,
  input  logic [`OMEGA_LANES-1:0]                    inValid_i,
  input  logic [`OMEGA_LANES-1:0]                    inReady_i,
  input  logic [`OMEGA_LANES-1:0][`OMEGA_DATA_W-1:0] inData_i,
  input  logic [`OMEGA_LANES-1:0][`OMEGA_DEST_W-1:0] inDest_i,
  input  logic [`OMEGA_LANES-1:0]                    outValid_i,
  input  logic [`OMEGA_LANES-1:0]                    outReady_i,
  input  logic [`OMEGA_LANES-1:0][`OMEGA_DATA_W-1:0] outData_i,
  input  logic [`OMEGA_LANES-1:0][`OMEGA_DEST_W-1:0] outSrc_i,
  output int                                         errCount_o,
  output int                                         delivered_o,
  output int                                         pending_o
);

  // Expected payloads, one queue per pair of output and source.
  // Words from one input to one output share a single path, so they keep their order.
  // Queue index is output * lanes + source.
  logic [`OMEGA_DATA_W-1:0] expQ [`OMEGA_LANES*`OMEGA_LANES][$];
  // Outputs that showed valid without ready at the last edge, and the word they showed.
  logic [`OMEGA_LANES-1:0] stalled;
  logic [`OMEGA_DEST_W+`OMEGA_DATA_W-1:0] stallWord [`OMEGA_LANES];
  // Set by the first accepted input word.
  logic sentAny;

  function automatic string testName(input logic [2:0] id);
    case (id)
      3'd1: return "reset";
      3'd2: return "latency";
      3'd3: return "permutation";
      3'd4: return "hot spot";
      3'd5: return "random back-pressure";
      default: return "setup";
    endcase
  endfunction

  // A delivered word must be the oldest one sent from its source to this output.
  task automatic checkDelivery(input int o);
    int idx;
    logic [`OMEGA_DATA_W-1:0] expWord;
    idx = o * `OMEGA_LANES + int'(outSrc_i[o]);
    assert (expQ[idx].size() > 0) else begin
      $display("%s: output %0d delivered a word from input %0d that nobody sent there.",
               testName(testId_i), o, outSrc_i[o]);
      errCount_o++;
    end
    if (expQ[idx].size() > 0) begin
      expWord = expQ[idx].pop_front();
      assert (outData_i[o] == expWord) else begin
        $display("FAILED %s: output %0d data from input %0d, expected %h, actual %h",
                 testName(testId_i), o, outSrc_i[o], expWord, outData_i[o]);
        errCount_o++;
      end
      pending_o--;
    end
    delivered_o++;
  endtask

  // All inputs are sampled at the rising edge, where the testbench holds them still.
  always @(posedge clk_i) begin
    if (rst_i) begin
      errCount_o  = 0;
      delivered_o = 0;
      pending_o   = 0;
      sentAny     = 1'b0;
      stalled     = '0;
      for (int i = 0; i < `OMEGA_LANES * `OMEGA_LANES; i++) begin
        expQ[i].delete();
      end
    end else begin
      // Nothing may come out of an empty network.
      if (!sentAny) begin
        assert (outValid_i == '0) else begin
          $display("FAILED %s: outValid before the first word, expected %h, actual %h",
                   testName(testId_i), 8'h00, outValid_i);
          errCount_o++;
        end
      end
      for (int o = 0; o < `OMEGA_LANES; o++) begin
        // A stalled output keeps its valid and its word until the transfer.
        if (stalled[o]) begin
          assert (outValid_i[o]) else begin
            $display("%s: output %0d dropped valid before its word was taken.",
                     testName(testId_i), o);
            errCount_o++;
          end
          if (outValid_i[o]) begin
            assert ({outSrc_i[o], outData_i[o]} == stallWord[o]) else begin
              $display("FAILED %s: output %0d held word, expected %h, actual %h",
                       testName(testId_i), o, stallWord[o], {outSrc_i[o], outData_i[o]});
              errCount_o++;
            end
          end
        end
        if (outValid_i[o] && outReady_i[o]) begin
          checkDelivery(o);
        end
        stalled[o]   = outValid_i[o] && !outReady_i[o];
        stallWord[o] = {outSrc_i[o], outData_i[o]};
      end
      // Every accepted word is expected once at the output that it names.
      for (int p = 0; p < `OMEGA_LANES; p++) begin
        if (inValid_i[p] && inReady_i[p]) begin
          expQ[int'(inDest_i[p]) * `OMEGA_LANES + p].push_back(inData_i[p]);
          pending_o++;
          sentAny = 1'b1;
        end
      end
    end
  end

endmodule

// File: verification/omegaNetTb.sv
// Testbench for the omega network top level; runs all traffic phases and prints the verdict.
`timescale 1ns/1ps
`include "omegaNet_defs.svh"

module omegaNetTb;

  localparam int waitLimit = 4000;
  // Traffic shapes for runTraffic.
  localparam int modePerm = 0;
  localparam int modeHot  = 1;
  localparam int modeRand = 2;

  logic clk;
  logic rst;
  logic [`OMEGA_LANES-1:0]                    inValid;
  logic [`OMEGA_LANES-1:0]                    inReady;
  logic [`OMEGA_LANES-1:0][`OMEGA_DATA_W-1:0] inData;
  logic [`OMEGA_LANES-1:0][`OMEGA_DEST_W-1:0] inDest;
  logic [`OMEGA_LANES-1:0]                    outValid;
  logic [`OMEGA_LANES-1:0]                    outReady;
  logic [`OMEGA_LANES-1:0][`OMEGA_DATA_W-1:0] outData;
  logic [`OMEGA_LANES-1:0][`OMEGA_DEST_W-1:0] outSrc;
  logic [2:0] testId;
  int chkErrors;
  int delivered;
  int pending;
  int tbErrors;
  int sentTotal;
  logic [31:0] lcgState;
  // Per-input sequence number, the low part of every payload.
  logic [12:0] seqNum [`OMEGA_LANES];
  // Sources seen at any output since the last clear.
  logic [`OMEGA_LANES-1:0] srcSeen;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  omegaNetTop DUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .inValid_i  (inValid),
    .inReady_o  (inReady),
    .inData_i   (inData),
    .inDest_i   (inDest),
    .outValid_o (outValid),
    .outReady_i (outReady),
    .outData_o  (outData),
    .outSrc_o   (outSrc)
  );

  omegaNetChecks uChecks (
    .clk_i       (clk),
    .rst_i       (rst),
    .testId_i    (testId),
    .inValid_i   (inValid),
    .inReady_i   (inReady),
    .inData_i    (inData),
    .inDest_i    (inDest),
    .outValid_i  (outValid),
    .outReady_i  (outReady),
    .outData_i   (outData),
    .outSrc_i    (outSrc),
    .errCount_o  (chkErrors),
    .delivered_o (delivered),
    .pending_o   (pending)
  );

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Level 0 pairs inputs that differ in bit 0 and steers by destination bit 2.
  // Rotating the input index before the XOR keeps every switch free of contention.
  function automatic logic [2:0] permDest(input int p, input logic [2:0] key);
    logic [2:0] pb;
    pb = 3'(p);
    return {pb[0], pb[2], pb[1]} ^ key;
  endfunction

  // The payload carries its source in the top bits and a sequence number below.
  task automatic loadWord(input int p, input int d);
    inValid[p] = 1'b1;
    inDest[p]  = `OMEGA_DEST_W'(d);
    inData[p]  = {`OMEGA_DEST_W'(p), seqNum[p]};
    seqNum[p]  = seqNum[p] + 1'b1;
  endtask

  task automatic noteDeliveries();
    for (int o = 0; o < `OMEGA_LANES; o++) begin
      if (outValid[o] && outReady[o]) begin
        srcSeen[outSrc[o]] = 1'b1;
      end
    end
  endtask

  task automatic printCounts();
    $display("Errors: %0d from checker assertions, %0d from testbench assertions.",
             chkErrors, tbErrors);
  endtask

  task automatic abortTimeout(input string what);
    $display("Timeout while waiting for %s in test %0d.", what, testId);
    printCounts();
    $display("*** FAILED ***");
    $finish;
  endtask

  // Waits until every accepted word has left the network.
  task automatic waitDrain(input string what);
    int cycles;
    cycles = 0;
    while (delivered != sentTotal) begin
      @(negedge clk);
      noteDeliveries();
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > waitLimit) abortTimeout(what);
    end
  endtask

  // Sends one word into an idle network and counts edges from acceptance to output valid.
  task automatic singleWord(input int p, input int d);
    int cycles;
    int waitCnt;
    loadWord(p, d);
    waitCnt = 0;
    @(negedge clk);
    while (!inReady[p]) begin
      waitCnt++;
      if (waitCnt > waitLimit) abortTimeout("input ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    inValid[p] = 1'b0;
    sentTotal++;
    cycles = 1;
    @(negedge clk);
    while (!outValid[d]) begin
      @(posedge clk);
      cycles++;
      if (cycles > waitLimit) abortTimeout("output valid");
      @(negedge clk);
    end
    assert (cycles == 3) else begin
      $display("FAILED latency: input %0d to output %0d, expected %0d cycles, actual %0d",
               p, d, 3, cycles);
      tbErrors++;
    end
    @(posedge clk);
    #1;
    waitDrain("the latency word to leave");
  endtask

  // Offers words on all inputs until each has sent its share, then drains the network.
  task automatic runTraffic(input int mode, input int words, input logic [2:0] hotDest);
    int left [`OMEGA_LANES];
    int cycles;
    int remaining;
    logic [`OMEGA_LANES-1:0] accepted;
    logic [31:0] rnd;
    logic [2:0] dest;
    for (int p = 0; p < `OMEGA_LANES; p++) begin
      left[p] = words;
    end
    remaining = words * `OMEGA_LANES;
    cycles = 0;
    while (inValid != '0 || remaining > 0) begin
      if (mode == modePerm) begin
        // A new permutation starts only once the previous one is fully taken.
        if (inValid == '0) begin
          rnd = nextRand();
          for (int p = 0; p < `OMEGA_LANES; p++) begin
            loadWord(p, int'(permDest(p, rnd[18:16])));
            left[p]--;
            remaining--;
          end
        end
      end else begin
        for (int p = 0; p < `OMEGA_LANES; p++) begin
          rnd = nextRand();
          dest = (mode == modeHot) ? hotDest : rnd[26:24];
          if (!inValid[p] && left[p] > 0 && (mode == modeHot || rnd[20])) begin
            loadWord(p, int'(dest));
            left[p]--;
            remaining--;
          end
        end
      end
      rnd = nextRand();
      outReady = (mode == modeRand) ? rnd[23:16] : '1;
      @(negedge clk);
      accepted = inValid & inReady;
      noteDeliveries();
      if (mode == modePerm) begin
        assert (accepted == inValid) else begin
          $display("FAILED permutation: input ready expected %h, actual %h", inValid, accepted);
          tbErrors++;
        end
      end
      @(posedge clk);
      #1;
      inValid = inValid & ~accepted;
      sentTotal += $countones(accepted);
      cycles++;
      if (cycles > waitLimit) abortTimeout("the inputs to be accepted");
    end
    outReady = '1;
    waitDrain("the network to drain");
  endtask

  initial begin
    logic [31:0] rnd;
    rst       = 1'b1;
    inValid   = '0;
    inData    = '0;
    inDest    = '0;
    outReady  = '1;
    testId    = 3'd0;
    tbErrors  = 0;
    sentTotal = 0;
    srcSeen   = '0;
    lcgState  = 32'h5c37;
    for (int p = 0; p < `OMEGA_LANES; p++) begin
      seqNum[p] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // An idle network after reset shows no valid output.
    testId = 3'd1;
    repeat (5) @(posedge clk);
    #1;
    for (int p = 0; p < `OMEGA_LANES; p++) begin
      rnd = nextRand();
      seqNum[p] = rnd[28:16];
    end

    testId = 3'd2;
    for (int p = 0; p < `OMEGA_LANES; p++) begin
      for (int d = 0; d < `OMEGA_LANES; d++) begin
        singleWord(p, d);
      end
    end

    testId = 3'd3;
    runTraffic(modePerm, 16, 3'd0);

    // Every input sends one word to the same output.
    testId = 3'd4;
    for (int i = 0; i < 3; i++) begin
      rnd = nextRand();
      srcSeen = '0;
      runTraffic(modeHot, 1, rnd[22:20]);
      assert (srcSeen == '1) else begin
        $display("FAILED hot spot: sources seen expected %h, actual %h", 8'hff, srcSeen);
        tbErrors++;
      end
    end

    testId = 3'd5;
    runTraffic(modeRand, 48, 3'd0);
    assert (pending == 0) else begin
      $display("FAILED scoreboard: words pending expected %0d, actual %0d", 0, pending);
      tbErrors++;
    end

    printCounts();
    if (chkErrors == 0 && tbErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: omegaNet.f
+incdir+include
hdl/omegaPktPkg.sv
hdl/omegaArbPkg.sv
hdl/omegaLinkIf.sv
hdl/rrArbiter.sv
hdl/spillRegister.sv
hdl/streamSwitch.sv
hdl/omegaNet.sv
hdl/omegaNetTop.sv
verification/omegaNetChecks.sv
verification/omegaNetTb.sv

// File: run.sh
#!/bin/sh
# Builds the omega network testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module omegaNetTb -f omegaNet.f -o omegaNetSim

./obj_dir/omegaNetSim | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed, see sim.log."
  exit 1
fi
